// ==== Makefile ====
# Verilator build and run for the streaming Hilbert transformer.
VERILATOR = verilator
FLAGS = --binary --assert --timing
TOP = hilbertBench
FILELIST = hilbertSubsystem.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result: any fail message, or a missing pass message, fails the run.
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/hilbertBench.sv ====
/* Hilbert transformer testbench.
   Streams LFSR, impulse and full-scale samples and checks the analytic output against a model. */
module hilbertBench;

	localparam int LENGTH = 27;
	localparam int CENTER = (LENGTH - 1) / 2;
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES = 20;
	localparam int SAMPLE_COUNT = 400;
	localparam int TAIL_CYCLES = 30;
	localparam int MARGIN = 100;

	// Idle, stop and tail cycles fit inside the margin.
	localparam int CYCLE_LIMIT = RESET_CYCLES + LENGTH + 1 + SAMPLE_COUNT + MARGIN;

	localparam hilbertPkg::sampleWord FULL_POS = {1'b0, {(hilbertPkg::SAMPLE_WIDTH-1){1'b1}}};
	localparam hilbertPkg::sampleWord FULL_NEG = {1'b1, {(hilbertPkg::SAMPLE_WIDTH-1){1'b0}}};

	logic clock;
	logic reset;
	logic enable;
	logic stop;
	hilbertPkg::sampleWord dataIn;
	hilbertPkg::analyticSample dataOut;
	logic running;

	logic [15:0] lfsrState = 16'd7177;
	int errorCount = 0;
	int samplesSent = 0;
	int cycleCount = 0;

	// Model state. history[0] is the newest sample taken while running.
	hilbertPkg::sampleWord history [LENGTH];
	hilbertPkg::accWord expIm [4];
	hilbertPkg::accWord expRe [4];
	logic [3:0] runPipe;
	logic enableSeen;
	logic stopSeen;

	hilbertTransform #(
		.LENGTH(LENGTH)
	) dut_i (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.stop(stop),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.running(running)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// One step of a 16-bit Galois LFSR with taps 16, 14, 13 and 11.
	function automatic logic [15:0] galoisStep(input logic [15:0] s);
		logic [15:0] next;
		next = s >> 1;
		if (s[0]) begin
			next = next ^ 16'hB400;
		end
		return next;
	endfunction

	// Builds one sample from 18 LFSR steps, one bit per step.
	task automatic drawSample(output hilbertPkg::sampleWord value);
		for (int b = 0; b < hilbertPkg::SAMPLE_WIDTH; b++) begin
			lfsrState = galoisStep(lfsrState);
			value = {value[hilbertPkg::SAMPLE_WIDTH-2:0], lfsrState[0]};
		end
	endtask

	// Random data, then an impulse with zeros on both sides, then full-scale steps of
	// both signs, then random again.
	task automatic chooseSample(input int n, output hilbertPkg::sampleWord value);
		if (n >= 200 - LENGTH && n < 200) begin
			value = '0;
		end else if (n == 200) begin
			value = FULL_POS;
		end else if (n > 200 && n < 240) begin
			value = '0;
		end else if (n >= 240 && n < 280) begin
			value = FULL_POS;
		end else if (n >= 280 && n < 320) begin
			value = FULL_NEG;
		end else begin
			drawSample(value);
		end
	endtask

	// Reference model. It mirrors the delay line from the samples taken while running
	// and pipes the expected parts so that they line up with dataOut at sampling time.
	always @(posedge clock) begin
		longint sum;
		if (reset) begin
			for (int i = 0; i < LENGTH; i++) begin
				history[i] = '0;
			end
			for (int k = 0; k < 4; k++) begin
				expIm[k] <= '0;
				expRe[k] <= '0;
			end
			runPipe <= '0;
			enableSeen <= 1'b0;
			stopSeen <= 1'b0;
		end else begin
			if (running) begin
				for (int i = LENGTH - 1; i > 0; i--) begin
					history[i] = history[i-1];
				end
				history[0] = dataIn;
			end
			sum = 0;
			for (int i = 0; i < LENGTH; i++) begin
				sum = sum + longint'(hilbertPkg::hilbertCoeff(i, LENGTH)) * longint'(history[i]);
			end
			expIm[0] <= hilbertPkg::accWord'(sum);
			expRe[0] <= hilbertPkg::accWord'(longint'(history[CENTER]) <<< hilbertPkg::COEFF_FRAC);
			for (int k = 1; k < 4; k++) begin
				expIm[k] <= expIm[k-1];
				expRe[k] <= expRe[k-1];
			end
			runPipe <= {runPipe[2:0], running};
			if (enable) begin
				enableSeen <= 1'b1;
			end
			if (stop && running) begin
				stopSeen <= 1'b1;
			end
		end
	end

	// runPipe[3] marks the sample edge, runPipe[1] the edge that gates the output register.
	assert property (@(posedge clock) disable iff (reset)
		(runPipe[1] && runPipe[3]) |-> dataOut.im == expIm[3])
	else begin
		errorCount++;
		$display("ERR dataOut.im expected %h actual %h", $sampled(expIm[3]), $sampled(dataOut.im));
	end

	assert property (@(posedge clock) disable iff (reset)
		(runPipe[1] && runPipe[3]) |-> dataOut.re == expRe[3])
	else begin
		errorCount++;
		$display("ERR dataOut.re expected %h actual %h", $sampled(expRe[3]), $sampled(dataOut.re));
	end

	// Outside the gated window the output register holds zero.
	assert property (@(posedge clock) disable iff (reset)
		!runPipe[1] |-> dataOut == '0)
	else begin
		errorCount++;
		$display("ERR dataOut expected %h actual %h", 72'h0, $sampled(dataOut));
	end

	// Nothing runs before the first enable.
	assert property (@(posedge clock) disable iff (reset)
		!enableSeen |-> !running)
	else begin
		errorCount++;
		$display("running went high before enable was given");
	end

	// The coefficient load takes LENGTH cycles plus the start pulse.
	assert property (@(posedge clock) disable iff (reset)
		(enable && !enableSeen) |=> (!running) [*LENGTH+1] ##1 running)
	else begin
		errorCount++;
		$display("running did not rise exactly LENGTH+1 cycles after enable");
	end

	assert property (@(posedge clock) disable iff (reset)
		(stop && running) |=> !running)
	else begin
		errorCount++;
		$display("running stayed high after stop was taken");
	end

	// The stopped state is terminal, even when enable comes back.
	assert property (@(posedge clock) disable iff (reset)
		stopSeen |-> !running)
	else begin
		errorCount++;
		$display("running came back after stop");
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Summary: %0d samples streamed, %0d errors", samplesSent, errorCount);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		hilbertPkg::sampleWord value;
		reset <= 1'b1;
		enable <= 1'b0;
		stop <= 1'b0;
		dataIn <= '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		// Random data while idle must not reach the output.
		repeat (IDLE_CYCLES) begin
			@(posedge clock);
			drawSample(value);
			dataIn <= value;
		end
		@(posedge clock);
		enable <= 1'b1;
		@(posedge clock);
		enable <= 1'b0;
		while (!running) begin
			@(posedge clock);
		end

		for (int n = 0; n < SAMPLE_COUNT; n++) begin
			chooseSample(n, value);
			dataIn <= value;
			samplesSent++;
			@(posedge clock);
		end
		stop <= 1'b1;
		@(posedge clock);
		stop <= 1'b0;

		// Enable again after stop. The block must stay stopped.
		enable <= 1'b1;
		repeat (TAIL_CYCLES) begin
			@(posedge clock);
			drawSample(value);
			dataIn <= value;
		end
		enable <= 1'b0;
		repeat (2) @(posedge clock);

		$display("Summary: %0d samples streamed, %0d errors", samplesSent, errorCount);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== hdl/coeffSequencer.sv ====
/* Coefficient sequencer.
   Streams the LENGTH Hilbert coefficients, one per clock, after a start pulse. */
module coeffSequencer #(
	parameter int LENGTH = 27
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 loadStart,
	output logic                 coeffValid,
	output hilbertPkg::coeffWord coeff,
	output logic                 loadDone
);

	localparam int COUNT_WIDTH = $clog2(LENGTH);

	// Tap index of the coefficient on the output. It counts down during the stream.
	logic [COUNT_WIDTH-1:0] tapIndex;

	// Coefficient table, fixed at elaboration.
	hilbertPkg::coeffWord coeffTable [LENGTH];

	// Each table entry is a constant computed by the package function.
	for (genvar i = 0; i < LENGTH; i++) begin : gTable
		localparam hilbertPkg::coeffWord VALUE = hilbertPkg::hilbertCoeff(i, LENGTH);
		assign coeffTable[i] = VALUE;
	end

	// The stream begins one cycle after loadStart with the far-end tap, LENGTH-1.
	// It walks down to tap 0 and then goes quiet.
	always_ff @(posedge clock) begin
		if (reset) begin
			coeffValid <= 1'b0;
			tapIndex <= '0;
		end else if (loadStart) begin
			coeffValid <= 1'b1;
			tapIndex <= COUNT_WIDTH'(LENGTH - 1);
		end else if (coeffValid) begin
			if (tapIndex == '0) begin
				coeffValid <= 1'b0;
			end else begin
				tapIndex <= tapIndex - 1'b1;
			end
		end
	end

	// The last coefficient of the stream is tap 0, so loadDone marks that cycle.
	assign loadDone = coeffValid && (tapIndex == '0);

	// Zero is driven outside the stream so the bus is quiet when not loading.
	assign coeff = coeffValid ? coeffTable[tapIndex] : '0;

	// A full stream lasts exactly LENGTH cycles, from the cycle after loadStart
	// to the loadDone cycle.
	assert property (@(posedge clock) disable iff (reset)
		loadStart |=> coeffValid [*LENGTH] ##0 loadDone)
	else $error("coefficient stream did not last LENGTH cycles");

	// The controller must not restart the stream while it is still running.
	assert property (@(posedge clock) disable iff (reset)
		!(loadStart && coeffValid))
	else $error("loadStart arrived during an active coefficient stream");

endmodule

// ==== hdl/firFilter.sv ====
/* Hilbert FIR filter.
   Loadable coefficient bank, sample delay line, pipelined multiply-add and aligned centre tap. */
module firFilter #(
	parameter int LENGTH = 27
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  coeffValid,
	input  hilbertPkg::coeffWord  coeff,
	input  logic                  sampleEnable,
	input  logic                  clearLine,
	input  hilbertPkg::sampleWord dataIn,
	output hilbertPkg::accWord    filterOut,
	output hilbertPkg::accWord    centerTap
);

	// Index of the centre tap, which is also the group delay in samples.
	localparam int CENTER = (LENGTH - 1) / 2;

	// Coefficient bank. Entry i multiplies the sample delayed by i.
	hilbertPkg::coeffWord coeffBank [LENGTH];

	// Sample delay line. Entry 0 holds the newest sample.
	hilbertPkg::sampleWord delayLine [LENGTH];

	// First pipeline stage: one registered product per tap.
	hilbertPkg::accWord products [LENGTH];

	// Scaled centre sample, registered beside the products.
	hilbertPkg::accWord centerStage;

	// Combinational sum of all registered products.
	hilbertPkg::accWord productSum;

	// Coefficients enter at entry 0 and move towards the far end. The sequencer sends
	// the far-end coefficient first, so after LENGTH shifts every tap holds its own value.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < LENGTH; i++) begin
				coeffBank[i] <= '0;
			end
		end else if (coeffValid) begin
			coeffBank[0] <= coeff;
			for (int i = 1; i < LENGTH; i++) begin
				coeffBank[i] <= coeffBank[i-1];
			end
		end
	end

	// The delay line takes one sample per clock while running.
	// Clearing has priority and empties the line once the run has stopped.
	always_ff @(posedge clock) begin
		if (reset || clearLine) begin
			for (int i = 0; i < LENGTH; i++) begin
				delayLine[i] <= '0;
			end
		end else if (sampleEnable) begin
			delayLine[0] <= dataIn;
			for (int i = 1; i < LENGTH; i++) begin
				delayLine[i] <= delayLine[i-1];
			end
		end
	end

	// Stage one registers every product and the centre sample.
	// Zero coefficients still get a multiplier, so any coefficient set fits the structure.
	// The centre sample is scaled to the same fixed point as the products.
	always_ff @(posedge clock) begin
		for (int i = 0; i < LENGTH; i++) begin
			products[i] <= coeffBank[i] * delayLine[i];
		end
		centerStage <= hilbertPkg::accWord'(delayLine[CENTER]) <<< hilbertPkg::COEFF_FRAC;
	end

	// Adder over all taps.
	always_comb begin
		productSum = '0;
		for (int i = 0; i < LENGTH; i++) begin
			productSum = productSum + products[i];
		end
	end

	// Stage two registers the sum. The centre sample passes a matching register,
	// so the real and imaginary parts leave the filter on the same clock.
	always_ff @(posedge clock) begin
		filterOut <= productSum;
		centerTap <= centerStage;
	end

	// Loading and streaming are separate phases of the controller.
	assert property (@(posedge clock) disable iff (reset)
		!(coeffValid && sampleEnable))
	else $error("coefficient load overlaps sample streaming");

	// Samples only flow after the bank has been filled by a full coefficient stream.
	assert property (@(posedge clock) disable iff (reset)
		$rose(sampleEnable) |-> $past(coeffValid, 1))
	else $error("sample streaming started without a preceding coefficient load");

endmodule

// ==== hdl/hilbertPkg.sv ====
/* Hilbert transformer package.
   Shared widths, the output and state types, and the Hilbert FIR coefficient function. */
package hilbertPkg;

	// Signed input sample width.
	localparam int SAMPLE_WIDTH = 18;

	// Signed coefficient width and its number of fraction bits.
	localparam int COEFF_WIDTH = 18;
	localparam int COEFF_FRAC = 16;

	// Width of each output part. It is twice the sample width, which leaves headroom
	// for the sum of 27 full-scale products.
	localparam int ACC_WIDTH = 2 * SAMPLE_WIDTH;

	localparam real PI = 3.14159265358979323846;

	typedef logic signed [SAMPLE_WIDTH-1:0] sampleWord;
	typedef logic signed [COEFF_WIDTH-1:0] coeffWord;
	typedef logic signed [ACC_WIDTH-1:0] accWord;

	// One analytic output sample. The real part sits in the upper half of the word.
	typedef struct packed {
		accWord re;
		accWord im;
	} analyticSample;

	// Control states of the transformer.
	typedef enum logic [1:0] {
		IDLE,
		LOADING,
		RUNNING,
		STOPPED
	} controlState;

	// Ideal Hilbert impulse response 2/(pi*k) at odd offsets k from the centre tap,
	// scaled by 2^COEFF_FRAC and rounded. Even offsets, the centre included, give zero.
	// Taps before the centre carry the negative half of the antisymmetric response.
	function automatic coeffWord hilbertCoeff(input int index, input int length);
		int center;
		int offset;
		int distance;
		real magnitude;
		int rounded;
		center = (length - 1) / 2;
		offset = index - center;
		distance = (offset < 0) ? -offset : offset;
		if ((distance % 2) == 0) begin
			return '0;
		end
		magnitude = 2.0 / (PI * real'(distance)) * real'(1 << COEFF_FRAC);
		// The cast to int rounds to the nearest integer.
		rounded = int'(magnitude);
		if (offset < 0) begin
			rounded = -rounded;
		end
		return coeffWord'(rounded);
	endfunction

endpackage

// ==== hdl/hilbertTransform.sv ====
/* Streaming Hilbert transformer.
   Loads the FIR coefficients on enable, then turns a real sample stream into an analytic one. */
module hilbertTransform #(
	parameter int LENGTH = 27
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      enable,
	input  logic                      stop,
	input  hilbertPkg::sampleWord     dataIn,
	output hilbertPkg::analyticSample dataOut,
	output logic                      running
);

	// Control state.
	hilbertPkg::controlState state;

	// One-cycle start pulse for the coefficient stream.
	logic loadStart;

	// Coefficient stream from the sequencer to the filter.
	logic coeffValid;
	hilbertPkg::coeffWord coeff;
	logic loadDone;

	// Filter control and results.
	logic sampleEnable;
	logic clearLine;
	hilbertPkg::accWord filterOut;
	hilbertPkg::accWord centerTap;

	// Copy of running from the previous edge. It gates the output register.
	logic runningQ;

	// The FSM waits for enable, loads the coefficients, streams samples until stop,
	// and then stays stopped until reset.
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= hilbertPkg::IDLE;
			loadStart <= 1'b0;
		end else begin
			loadStart <= 1'b0;
			case (state)
				hilbertPkg::IDLE: begin
					if (enable) begin
						state <= hilbertPkg::LOADING;
						loadStart <= 1'b1;
					end
				end
				hilbertPkg::LOADING: begin
					// loadDone marks the last coefficient, which the bank takes on this edge.
					if (loadDone) begin
						state <= hilbertPkg::RUNNING;
					end
				end
				hilbertPkg::RUNNING: begin
					if (stop) begin
						state <= hilbertPkg::STOPPED;
					end
				end
				default: begin
					state <= hilbertPkg::STOPPED;
				end
			endcase
		end
	end

	assign running = (state == hilbertPkg::RUNNING);
	assign sampleEnable = running;
	assign clearLine = (state == hilbertPkg::STOPPED);

	coeffSequencer #(
		.LENGTH(LENGTH)
	) coeffSequencer_i (
		.clock(clock),
		.reset(reset),
		.loadStart(loadStart),
		.coeffValid(coeffValid),
		.coeff(coeff),
		.loadDone(loadDone)
	);

	firFilter #(
		.LENGTH(LENGTH)
	) firFilter_i (
		.clock(clock),
		.reset(reset),
		.coeffValid(coeffValid),
		.coeff(coeff),
		.sampleEnable(sampleEnable),
		.clearLine(clearLine),
		.dataIn(dataIn),
		.filterOut(filterOut),
		.centerTap(centerTap)
	);

	// The output register passes filter results only while the previous edge was running.
	// Everything else, including the samples still in flight at stop, is replaced by zero.
	always_ff @(posedge clock) begin
		if (reset) begin
			runningQ <= 1'b0;
			dataOut <= '0;
		end else begin
			runningQ <= running;
			if (runningQ) begin
				dataOut.re <= centerTap;
				dataOut.im <= filterOut;
			end else begin
				dataOut <= '0;
			end
		end
	end

	// The sequencer finishes its stream only while the controller is loading.
	assert property (@(posedge clock) disable iff (reset)
		loadDone |-> (state == hilbertPkg::LOADING))
	else $error("loadDone seen outside LOADING");

endmodule

// ==== hilbertSubsystem.f ====
hdl/hilbertPkg.sv
hdl/coeffSequencer.sv
hdl/firFilter.sv
hdl/hilbertTransform.sv
bench/hilbertBench.sv
